/* sim.f */
hw/csr_pkg.sv
hw/csr_if.sv
hw/csr_decode.sv
hw/csr_file.sv
hw/csr_timer.sv
hw/csr_result.sv
hw/csr_unit.sv
tests/csr_tb_clock.sv
tests/csr_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tests/csr_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

    localparam logic [31:0] seed = 32'h66d00542;
    localparam int op_budget = 160;
    localparam int tmr_init1 = 60;
    localparam int tmr_init2 = 24;
    localparam int tmr_margin = 16;
    localparam int watchdog_cycles = op_budget * 40 + tmr_init1 + tmr_init2 + 2 * tmr_margin;

    typedef struct packed {
        logic        chk;
        logic        chk_rd;
        logic [31:0] rd;
        logic        redir;
        logic [31:0] pc;
        logic        excp;
        logic        ertn;
    } exp_t;

    logic                   clk;
    logic                   rstn;
    logic                   op_valid;
    csr_pkg::csr_op_e       op_kind;
    logic [13:0]            csr_num;
    logic [31:0]            wr_data;
    logic [31:0]            wr_mask;
    logic [31:0]            op_pc;
    logic [5:0]             excp_ecode;
    logic [8:0]             excp_esubcode;
    logic [31:0]            excp_vaddr;
    logic [7:0]             hw_int;
    logic                   ipi;
    logic [31:0]            rd_data;
    logic                   redirect;
    logic [31:0]            redirect_pc;
    logic                   excp_flush;
    logic                   ertn_flush;
    logic [8:0]             crmd;

    exp_t cur_exp = '0;
    exp_t s1 = '0;      // expectation, one edge after the strobe
    exp_t s2 = '0;
    int errors = 0;
    int n_ops = 0;
    logic [31:0] last_rd;

    // reference state
    logic [8:0]  m_crmd;
    logic [2:0]  m_prmd;
    logic        m_euen;
    logic [12:0] m_ecfg;
    logic [1:0]  m_is;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [31:0] m_save [4];
    logic [31:0] m_tid;
    logic [31:0] m_tcfg;

    csr_tb_clock #(.period_ns(20), .rst_cycles(3)) u_clock (.clk(clk), .rstn(rstn));

    csr_unit UUT (
        .clk(clk), .rstn(rstn), .op_valid(op_valid), .op_kind(op_kind), .csr_num(csr_num),
        .wr_data(wr_data), .wr_mask(wr_mask), .op_pc(op_pc), .excp_ecode(excp_ecode),
        .excp_esubcode(excp_esubcode), .excp_vaddr(excp_vaddr), .hw_int(hw_int), .ipi(ipi),
        .rd_data(rd_data), .redirect(redirect), .redirect_pc(redirect_pc),
        .excp_flush(excp_flush), .ertn_flush(ertn_flush), .crmd(crmd)
    );

    always @(posedge clk)
    begin
        s1 <= cur_exp;
        s2 <= s1;
    end

    a_rd_data: assert property (@(posedge clk) disable iff (!rstn)
        s2.chk && s2.chk_rd |-> rd_data == s2.rd)
        else value_error("rd_data", $sampled(s2.rd), $sampled(rd_data));
    a_redirect: assert property (@(posedge clk) disable iff (!rstn)
        s2.chk |-> redirect == s2.redir)
        else value_error("redirect", {31'b0, $sampled(s2.redir)}, {31'b0, $sampled(redirect)});
    a_redirect_pc: assert property (@(posedge clk) disable iff (!rstn)
        s2.chk && s2.redir |-> redirect_pc == s2.pc)
        else value_error("redirect_pc", $sampled(s2.pc), $sampled(redirect_pc));
    a_excp_flush: assert property (@(posedge clk) disable iff (!rstn)
        s2.chk |-> excp_flush == s2.excp)
        else value_error("excp_flush", {31'b0, $sampled(s2.excp)}, {31'b0, $sampled(excp_flush)});
    a_ertn_flush: assert property (@(posedge clk) disable iff (!rstn)
        s2.chk |-> ertn_flush == s2.ertn)
        else value_error("ertn_flush", {31'b0, $sampled(s2.ertn)}, {31'b0, $sampled(ertn_flush)});

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
        errors++;
        $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got == exp) else value_error(name, exp, got);
    endtask

    function automatic logic [31:0] model_read(input logic [13:0] num);
        case (num)
            csr_pkg::csr_crmd:   return {23'b0, m_crmd};
            csr_pkg::csr_prmd:   return {29'b0, m_prmd};
            csr_pkg::csr_euen:   return {31'b0, m_euen};
            csr_pkg::csr_ecfg:   return {19'b0, m_ecfg};
            csr_pkg::csr_estat:  return {1'b0, m_esub, m_ecode, 14'b0, m_is}; // no hw lines
            csr_pkg::csr_era:    return m_era;
            csr_pkg::csr_badv:   return m_badv;
            csr_pkg::csr_eentry: return m_eentry;
            csr_pkg::csr_save0, csr_pkg::csr_save1,
            csr_pkg::csr_save2, csr_pkg::csr_save3: return m_save[num[1:0]];
            csr_pkg::csr_tid:    return m_tid;
            csr_pkg::csr_tcfg:   return m_tcfg;
            default:             return 32'h0;
        endcase
    endfunction

    task automatic model_write(input logic [13:0] num, input logic [31:0] v);
        case (num)
            csr_pkg::csr_crmd:   m_crmd = v[8:0];
            csr_pkg::csr_prmd:   m_prmd = v[2:0];
            csr_pkg::csr_euen:   m_euen = v[0];
            csr_pkg::csr_ecfg:   m_ecfg = v[12:0] & 13'h1bff;
            csr_pkg::csr_estat:  m_is = v[1:0];
            csr_pkg::csr_era:    m_era = v;
            csr_pkg::csr_badv:   m_badv = v;
            csr_pkg::csr_eentry: m_eentry = v & 32'hffffffc0;
            csr_pkg::csr_save0, csr_pkg::csr_save1,
            csr_pkg::csr_save2, csr_pkg::csr_save3: m_save[num[1:0]] = v;
            csr_pkg::csr_tid:    m_tid = v;
            csr_pkg::csr_tcfg:   m_tcfg = v;
            default: ;
        endcase
    endtask

    task automatic model_entry(input logic [31:0] pc, input logic [5:0] ecode,
                               input logic [8:0] esub, input logic [31:0] vaddr);
        m_prmd = m_crmd[2:0];
        m_crmd[2:0] = 3'b0;
        m_era = pc;
        m_ecode = ecode;
        m_esub = esub;
        if (ecode inside {csr_pkg::ecode_ale, csr_pkg::ecode_pil, csr_pkg::ecode_pis,
                          csr_pkg::ecode_pif, csr_pkg::ecode_pme, csr_pkg::ecode_ppi} ||
            (ecode == csr_pkg::ecode_ade && esub == 9'h001))
            m_badv = vaddr;
    endtask

    function automatic logic [31:0] next_pc();
        logic [31:0] r;
        r = $urandom();
        return r & 32'hfffffffc;
    endfunction

    task automatic do_op(input csr_pkg::csr_op_e kind, input logic [13:0] num,
                         input logic [31:0] wdata, input logic [31:0] wmask,
                         input logic [31:0] pc, input logic [5:0] ecode,
                         input logic [8:0] esub, input logic [31:0] vaddr, input bit chk_rd);
        exp_t e;
        logic [31:0] old;
        e = '0;
        e.chk = 1'b1;
        e.chk_rd = chk_rd;
        old = model_read(num);
        case (kind)
            csr_pkg::op_rd: e.rd = old;
            csr_pkg::op_wr, csr_pkg::op_xchg:
            begin
                e.rd = old;
                e.redir = 1'b1;
                e.pc = pc + 32'd4;
                model_write(num, kind == csr_pkg::op_xchg ? ((old & ~wmask) | (wdata & wmask))
                                                          : wdata);
            end
            csr_pkg::op_excp:
            begin
                e.redir = 1'b1;
                e.pc = m_eentry;
                e.excp = 1'b1;
                model_entry(pc, ecode, esub, vaddr);
            end
            default:
            begin
                e.redir = 1'b1;   // ertn
                e.pc = m_era;
                e.ertn = 1'b1;
                m_crmd[2:0] = m_prmd;
            end
        endcase
        op_kind = kind;
        csr_num = num;
        wr_data = wdata;
        wr_mask = wmask;
        op_pc = pc;
        excp_ecode = ecode;
        excp_esubcode = esub;
        excp_vaddr = vaddr;
        op_valid = 1'b1;
        cur_exp = e;
        @(posedge clk);
        #1;
        op_valid = 1'b0;
        cur_exp = '0;
        @(posedge clk);
        #1;
        last_rd = rd_data;
        n_ops++;
        check_val("crmd", {23'b0, m_crmd}, {23'b0, crmd});
    endtask

    task automatic rd(input logic [13:0] num, input bit chk);
        do_op(csr_pkg::op_rd, num, '0, '0, next_pc(), '0, '0, '0, chk);
    endtask

    task automatic wr(input logic [13:0] num, input logic [31:0] data);
        do_op(csr_pkg::op_wr, num, data, '0, next_pc(), '0, '0, '0, 1'b1);
    endtask

    task automatic xchg(input logic [13:0] num, input logic [31:0] data, input logic [31:0] mask);
        do_op(csr_pkg::op_xchg, num, data, mask, next_pc(), '0, '0, '0, 1'b1);
    endtask

    // interrupt entry with no op on the strobe
    task automatic wait_entry(input logic [31:0] pc, input int limit, input string what);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        op_pc = pc;
        while (!seen && n < limit)
        begin
            @(posedge clk);
            #1;
            seen = excp_flush;
            n++;
        end
        if (!seen)
        begin
            errors++;
            $display("%s: no interrupt entry within %0d cycles", what, limit);
        end
        else
        begin
            check_val("redirect_pc", m_eentry, redirect_pc);
            model_entry(pc, csr_pkg::ecode_int, '0, '0);
            check_val("crmd", {23'b0, m_crmd}, {23'b0, crmd});
        end
    endtask

    function automatic logic [13:0] kept_reg(input int i);
        case (i)
            0: return csr_pkg::csr_crmd;
            1: return csr_pkg::csr_prmd;
            2: return csr_pkg::csr_euen;
            3: return csr_pkg::csr_ecfg;
            4: return csr_pkg::csr_estat;
            5: return csr_pkg::csr_era;
            6: return csr_pkg::csr_badv;
            7: return csr_pkg::csr_eentry;
            8: return csr_pkg::csr_tid;
            9: return csr_pkg::csr_save0;
            10: return csr_pkg::csr_save1;
            11: return csr_pkg::csr_save2;
            12: return csr_pkg::csr_save3;
            13: return csr_pkg::csr_tcfg;
            14: return csr_pkg::csr_tval;
            default: return csr_pkg::csr_ticlr;
        endcase
    endfunction

    initial
    begin
        logic [31:0] v1;
        int cycles;
        void'($urandom(seed));
        op_valid = 1'b0;
        op_kind = csr_pkg::op_rd;
        csr_num = '0;
        wr_data = '0;
        wr_mask = '0;
        op_pc = '0;
        excp_ecode = '0;
        excp_esubcode = '0;
        excp_vaddr = '0;
        hw_int = '0;
        ipi = 1'b0;
        m_crmd = 9'h008;
        {m_prmd, m_euen, m_ecfg, m_is, m_ecode, m_esub} = '0;
        {m_era, m_badv, m_eentry, m_tid, m_tcfg} = '0;
        m_save = '{default: '0};
        @(posedge rstn);
        @(posedge clk);
        #1;
        check_val("rd_data", 32'h0, rd_data);
        check_val("excp_flush", 32'h0, {31'b0, excp_flush});
        check_val("ertn_flush", 32'h0, {31'b0, ertn_flush});
        check_val("crmd", {23'b0, m_crmd}, {23'b0, crmd});
        for (int i = 0; i < 16; i++)
            rd(kept_reg(i), 1'b1);

        for (int r = 0; r < 3; r++)
            for (int i = 7; i < 13; i++)    // eentry, tid, save0 to save3
            begin
                wr(kept_reg(i), $urandom());
                xchg(kept_reg(i), $urandom(), $urandom());
                rd(kept_reg(i), 1'b1);
            end

        wr(csr_pkg::csr_crmd, 32'h0b);      // plv3, ie off
        do_op(csr_pkg::op_excp, '0, '0, '0, next_pc(), csr_pkg::ecode_ale, '0, $urandom(), 1'b1);
        for (int i = 0; i < 7; i++)
            if (i != 3)
                rd(kept_reg(i), 1'b1);
        do_op(csr_pkg::op_ertn, '0, '0, '0, next_pc(), '0, '0, '0, 1'b1);
        rd(csr_pkg::csr_crmd, 1'b1);
        rd(csr_pkg::csr_prmd, 1'b1);

        wr(csr_pkg::csr_estat, 32'h1);
        wr(csr_pkg::csr_ecfg, 32'h3);
        wr(csr_pkg::csr_crmd, 32'h0c);
        wait_entry(next_pc(), 8, "software interrupt");
        for (int i = 0; i < 6; i++)
            if (i != 2 && i != 3)
                rd(kept_reg(i), 1'b1);
        wr(csr_pkg::csr_estat, 32'h0);
        wr(csr_pkg::csr_ecfg, 32'h0);

        wr(csr_pkg::csr_tcfg, tmr_init1 | 1);   // one-shot
        rd(csr_pkg::csr_tcfg, 1'b1);
        rd(csr_pkg::csr_tval, 1'b0);
        v1 = last_rd;
        rd(csr_pkg::csr_tval, 1'b0);
        assert (last_rd < v1 && v1 <= tmr_init1)
        else
        begin
            errors++;
            $display("tval does not count down: %h then %h", v1, last_rd);
        end
        cycles = 0;
        last_rd = '0;
        while (!last_rd[csr_pkg::timer_int_bit] && cycles < tmr_init1 + tmr_margin)
        begin
            rd(csr_pkg::csr_estat, 1'b0);
            cycles += 2;
        end
        if (!last_rd[csr_pkg::timer_int_bit])
        begin
            errors++;
            $display("timer bit of estat never set");
        end
        wr(csr_pkg::csr_ticlr, 32'h1);
        rd(csr_pkg::csr_estat, 1'b1);
        rd(csr_pkg::csr_tval, 1'b0);
        check_val("tval", 32'hffffffff, last_rd);   // one-shot parks

        wr(csr_pkg::csr_ecfg, 32'h800);
        wr(csr_pkg::csr_crmd, 32'h0c);
        wr(csr_pkg::csr_tcfg, tmr_init2 | 1);
        wait_entry(next_pc(), tmr_init2 + tmr_margin, "timer interrupt");
        rd(csr_pkg::csr_estat, 1'b0);
        check_val("estat.ecode", 32'h0, {26'b0, last_rd[21:16]});
        check_val("estat.ti", 32'h1, {31'b0, last_rd[csr_pkg::timer_int_bit]});
        wr(csr_pkg::csr_ticlr, 32'h1);
        wr(csr_pkg::csr_tcfg, 32'h0);
        for (int i = 0; i < 6; i++)
            rd(kept_reg(i), 1'b1);

        repeat (4) @(posedge clk);
        $display("%0d ops, %0d errors", n_ops, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/csr_tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_tb_clock #(
    parameter int period_ns = 20,
    parameter int rst_cycles = 3
) (
    output logic clk,
    output logic rstn
);

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release just after an edge, like the stimulus
    initial
    begin
        rstn = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #1 rstn = 1'b1;
    end

endmodule

`default_nettype wire

/* hw/csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            op_valid,
    input  csr_pkg::csr_op_e                op_kind,
    input  logic [csr_pkg::csr_num_w-1:0]   csr_num,
    input  logic [csr_pkg::xlen-1:0]        wr_data,
    input  logic [csr_pkg::xlen-1:0]        wr_mask,
    input  logic [csr_pkg::xlen-1:0]        op_pc,
    input  logic [csr_pkg::ecode_w-1:0]     excp_ecode,
    input  logic [csr_pkg::esubcode_w-1:0]  excp_esubcode,
    input  logic [csr_pkg::xlen-1:0]        excp_vaddr,
    input  logic [7:0]                      hw_int,
    input  logic                            ipi,
    output logic [csr_pkg::xlen-1:0]        rd_data,
    output logic                            redirect,
    output logic [csr_pkg::xlen-1:0]        redirect_pc,
    output logic                            excp_flush,
    output logic                            ertn_flush,
    output logic [8:0]                      crmd
);

    csr_op_if       op_bus ();
    csr_timer_if    tmr_bus ();

    logic                   int_req;
    csr_pkg::csr_result_t   res;

    csr_decode u_decode (
        .clk           (clk),
        .rstn          (rstn),
        .op_valid      (op_valid),
        .op_kind       (op_kind),
        .csr_num       (csr_num),
        .wr_data       (wr_data),
        .wr_mask       (wr_mask),
        .op_pc         (op_pc),
        .excp_ecode    (excp_ecode),
        .excp_esubcode (excp_esubcode),
        .excp_vaddr    (excp_vaddr),
        .int_req       (int_req),
        .op            (op_bus.src)
    );

    csr_file u_file (
        .clk     (clk),
        .rstn    (rstn),
        .op      (op_bus.dst),
        .tmr     (tmr_bus.ctrl),
        .hw_int  (hw_int),
        .ipi     (ipi),
        .int_req (int_req),
        .res     (res),
        .crmd    (crmd)
    );

    csr_timer u_timer (
        .clk  (clk),
        .rstn (rstn),
        .t    (tmr_bus.tmr)
    );

    csr_result u_result (
        .clk         (clk),
        .rstn        (rstn),
        .res         (res),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

/* hw/csr_result.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_result (
    input  logic                        clk,
    input  logic                        rstn,
    input  csr_pkg::csr_result_t        res,
    output logic [csr_pkg::xlen-1:0]    rd_data,
    output logic                        redirect,
    output logic                        excp_flush,
    output logic                        ertn_flush,
    output logic [csr_pkg::xlen-1:0]    redirect_pc
);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            rd_data    <= '0;
            redirect   <= 1'b0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            rd_data    <= res.rd_data;
            redirect   <= res.redirect;
            excp_flush <= res.excp_taken;  // one pulse per entry
            ertn_flush <= res.ertn_taken;
        end
    end

    always_ff @(posedge clk)
    begin
        redirect_pc <= res.redirect_pc;
    end

    a_target_aligned: assert property (@(posedge clk) disable iff (!rstn)
        redirect |-> redirect_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hw/csr_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
    input  logic        clk,
    input  logic        rstn,
    csr_timer_if.tmr    t
);

    logic [csr_pkg::xlen-1:0] init_val;
    logic                     at_zero;

    assign init_val = {t.tcfg[31:2], 2'b00};
    assign at_zero = t.tval == '0;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            t.tcfg       <= '0;
            t.tval       <= '0;
            t.ti_pending <= 1'b0;
        end
        else
        begin
            if (t.tcfg_we)
            begin
                t.tcfg <= t.wdata;
                if (t.wdata[0])
                    t.tval <= {t.wdata[31:2], 2'b00};
            end
            else if (t.tcfg[0])
            begin
                if (at_zero && t.tcfg[1])
                    t.tval <= init_val;     // periodic reload
                else if (t.tval != '1)
                    t.tval <= t.tval - 1'b1; // one-shot parks at all ones
            end

            if (t.ticlr)
                t.ti_pending <= 1'b0;
            else if (t.tcfg[0] && at_zero && !t.tcfg_we)
                t.ti_pending <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  logic                    clk,
    input  logic                    rstn,
    csr_op_if.dst                   op,
    csr_timer_if.ctrl               tmr,
    input  logic [7:0]              hw_int,
    input  logic                    ipi,
    output logic                    int_req,
    output csr_pkg::csr_result_t    res,
    output logic [8:0]              crmd
);

    logic [2:0]                     prmd;
    logic                           euen;
    logic [csr_pkg::int_w-1:0]      ecfg_lie;
    logic [1:0]                     estat_is;
    logic [csr_pkg::ecode_w-1:0]    estat_ecode;
    logic [csr_pkg::esubcode_w-1:0] estat_esubcode;
    logic [csr_pkg::xlen-1:0]       era;
    logic [csr_pkg::xlen-1:0]       badv;
    logic [31:6]                    eentry;
    logic [csr_pkg::xlen-1:0]       save [4];
    logic [csr_pkg::xlen-1:0]       tid;

    logic [csr_pkg::int_w-1:0]      pending;
    logic [csr_pkg::xlen-1:0]       rdata;
    logic [csr_pkg::xlen-1:0]       merged;
    logic                           is_wr;
    logic                           is_entry;
    logic                           is_ertn;
    logic                           badv_we;

    always_comb
    begin
        pending = {ipi, 1'b0, 1'b0, hw_int, estat_is};
        pending[csr_pkg::timer_int_bit] = tmr.ti_pending;
    end

    assign int_req = |(pending & ecfg_lie) && crmd[2];

    always_comb
    begin
        case (op.num)
            csr_pkg::csr_crmd:   rdata = {23'b0, crmd};
            csr_pkg::csr_prmd:   rdata = {29'b0, prmd};
            csr_pkg::csr_euen:   rdata = {31'b0, euen};
            csr_pkg::csr_ecfg:   rdata = {19'b0, ecfg_lie};
            csr_pkg::csr_estat:  rdata = {1'b0, estat_esubcode, estat_ecode, 3'b0, pending};
            csr_pkg::csr_era:    rdata = era;
            csr_pkg::csr_badv:   rdata = badv;
            csr_pkg::csr_eentry: rdata = {eentry, 6'b0};
            csr_pkg::csr_save0, csr_pkg::csr_save1,
            csr_pkg::csr_save2, csr_pkg::csr_save3: rdata = save[op.num[1:0]];
            csr_pkg::csr_tid:    rdata = tid;
            csr_pkg::csr_tcfg:   rdata = tmr.tcfg;
            csr_pkg::csr_tval:   rdata = tmr.tval;
            default:             rdata = '0; // ticlr reads zero
        endcase
    end

    assign merged = (op.kind == csr_pkg::op_xchg) ?
                    ((rdata & ~op.wmask) | (op.wdata & op.wmask)) : op.wdata;
    assign is_wr = op.valid && (op.kind == csr_pkg::op_wr || op.kind == csr_pkg::op_xchg);
    assign is_entry = op.valid && op.kind == csr_pkg::op_excp;
    assign is_ertn = op.valid && op.kind == csr_pkg::op_ertn;

    assign tmr.tcfg_we = is_wr && op.num == csr_pkg::csr_tcfg;
    assign tmr.ticlr = is_wr && op.num == csr_pkg::csr_ticlr && merged[0];
    assign tmr.wdata = merged;

    always_comb
    begin
        case (op.ecode)
            csr_pkg::ecode_ale, csr_pkg::ecode_pil, csr_pkg::ecode_pis,
            csr_pkg::ecode_pif, csr_pkg::ecode_pme, csr_pkg::ecode_ppi: badv_we = 1'b1;
            csr_pkg::ecode_ade: badv_we = op.esubcode == csr_pkg::esubcode_adem;
            default:            badv_we = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd           <= csr_pkg::crmd_reset;
            prmd           <= '0;
            euen           <= 1'b0;
            ecfg_lie       <= '0;
            estat_is       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            badv           <= '0;
            eentry         <= '0;
            save           <= '{default: '0};
            tid            <= '0;
        end
        else if (is_entry)
        begin
            prmd           <= crmd[2:0];
            crmd[2:0]      <= 3'b0;   // plv0, ie off
            era            <= op.pc;
            estat_ecode    <= op.ecode;
            estat_esubcode <= op.esubcode;
            if (badv_we)
                badv <= op.vaddr;
        end
        else if (is_ertn)
            crmd[2:0] <= prmd;
        else if (is_wr)
        begin
            case (op.num)
                csr_pkg::csr_crmd:   crmd <= merged[8:0];
                csr_pkg::csr_prmd:   prmd <= merged[2:0];
                csr_pkg::csr_euen:   euen <= merged[0];
                csr_pkg::csr_ecfg:   ecfg_lie <= merged[12:0] & 13'h1bff;
                csr_pkg::csr_estat:  estat_is <= merged[1:0]; // only the sw bits
                csr_pkg::csr_era:    era <= merged;
                csr_pkg::csr_badv:   badv <= merged;
                csr_pkg::csr_eentry: eentry <= merged[31:6];
                csr_pkg::csr_save0, csr_pkg::csr_save1,
                csr_pkg::csr_save2, csr_pkg::csr_save3: save[op.num[1:0]] <= merged;
                csr_pkg::csr_tid:    tid <= merged;
                default: ;
            endcase
        end
    end

    always_comb
    begin
        res = '0;
        if (op.valid)
        begin
            case (op.kind)
                csr_pkg::op_rd:
                    res.rd_data = rdata;
                csr_pkg::op_wr, csr_pkg::op_xchg:
                begin
                    res.rd_data     = rdata;  // old value
                    res.redirect    = 1'b1;
                    res.redirect_pc = op.pc + 32'd4;
                end
                csr_pkg::op_excp:
                begin
                    res.redirect    = 1'b1;
                    res.redirect_pc = {eentry, 6'b0};
                    res.excp_taken  = 1'b1;
                end
                csr_pkg::op_ertn:
                begin
                    res.redirect    = 1'b1;
                    res.redirect_pc = era;
                    res.ertn_taken  = 1'b1;
                end
                default: ;
            endcase
        end
    end

    a_no_entry_and_ertn: assert property (@(posedge clk) disable iff (!rstn)
        !(res.excp_taken && res.ertn_taken));

endmodule

`default_nettype wire

/* hw/csr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            op_valid,
    input  csr_pkg::csr_op_e                op_kind,
    input  logic [csr_pkg::csr_num_w-1:0]   csr_num,
    input  logic [csr_pkg::xlen-1:0]        wr_data,
    input  logic [csr_pkg::xlen-1:0]        wr_mask,
    input  logic [csr_pkg::xlen-1:0]        op_pc,
    input  logic [csr_pkg::ecode_w-1:0]     excp_ecode,
    input  logic [csr_pkg::esubcode_w-1:0]  excp_esubcode,
    input  logic [csr_pkg::xlen-1:0]        excp_vaddr,
    input  logic                            int_req,
    csr_op_if.src                           op
);

    logic entry_busy;   // entry sits in the op register
    logic take_int;

    // crmd.ie only drops when the entry commits
    assign take_int = int_req && !entry_busy;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            op.valid   <= 1'b0;
            entry_busy <= 1'b0;
        end
        else
        begin
            op.valid   <= op_valid || take_int;
            entry_busy <= take_int || (op_valid && op_kind == csr_pkg::op_excp);
        end
    end

    always_ff @(posedge clk)
    begin
        if (take_int)
        begin
            // interrupt wins, the op of this cycle is dropped
            op.kind     <= csr_pkg::op_excp;
            op.num      <= '0;
            op.wdata    <= '0;
            op.wmask    <= '0;
            op.ecode    <= csr_pkg::ecode_int;
            op.esubcode <= '0;
            op.vaddr    <= op_pc;
        end
        else
        begin
            op.kind     <= op_kind;
            op.num      <= csr_num;
            op.wdata    <= wr_data;
            op.wmask    <= wr_mask;
            op.ecode    <= excp_ecode;
            op.esubcode <= excp_esubcode;
            op.vaddr    <= excp_vaddr;
        end
        op.pc <= op_pc;
    end

    a_kind_known: assert property (@(posedge clk) disable iff (!rstn)
        op.valid |-> !$isunknown(op.kind));

endmodule

`default_nettype wire

/* hw/csr_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one registered op from decode
interface csr_op_if;
    logic                               valid;
    csr_pkg::csr_op_e                   kind;
    logic [csr_pkg::csr_num_w-1:0]      num;
    logic [csr_pkg::xlen-1:0]           wdata;
    logic [csr_pkg::xlen-1:0]           wmask;
    logic [csr_pkg::xlen-1:0]           pc;
    logic [csr_pkg::ecode_w-1:0]        ecode;
    logic [csr_pkg::esubcode_w-1:0]     esubcode;
    logic [csr_pkg::xlen-1:0]           vaddr;

    modport src (
        output valid, kind, num, wdata, wmask, pc, ecode, esubcode, vaddr
    );
    modport dst (
        input valid, kind, num, wdata, wmask, pc, ecode, esubcode, vaddr
    );
endinterface

interface csr_timer_if;
    logic                       tcfg_we;
    logic                       ticlr;      // clear request, bit 0 of the write
    logic [csr_pkg::xlen-1:0]   wdata;
    logic [csr_pkg::xlen-1:0]   tcfg;
    logic [csr_pkg::xlen-1:0]   tval;
    logic                       ti_pending;

    modport ctrl (
        output tcfg_we, ticlr, wdata,
        input  tcfg, tval, ti_pending
    );
    modport tmr (
        input  tcfg_we, ticlr, wdata,
        output tcfg, tval, ti_pending
    );
endinterface

`default_nettype wire

/* hw/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int xlen = 32;
    localparam int csr_num_w = 14;

    typedef enum logic [2:0] {
        op_rd   = 3'd0,
        op_wr   = 3'd1,
        op_xchg = 3'd2,
        op_excp = 3'd3,
        op_ertn = 3'd4
    } csr_op_e;

    // csr numbers
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h000;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h001;
    localparam logic [csr_num_w-1:0] csr_euen   = 14'h002;
    localparam logic [csr_num_w-1:0] csr_ecfg   = 14'h004;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h005;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h006;
    localparam logic [csr_num_w-1:0] csr_badv   = 14'h007;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'h00c;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h030;
    localparam logic [csr_num_w-1:0] csr_save1  = 14'h031;
    localparam logic [csr_num_w-1:0] csr_save2  = 14'h032;
    localparam logic [csr_num_w-1:0] csr_save3  = 14'h033;
    localparam logic [csr_num_w-1:0] csr_tid    = 14'h040;
    localparam logic [csr_num_w-1:0] csr_tcfg   = 14'h041;
    localparam logic [csr_num_w-1:0] csr_tval   = 14'h042;
    localparam logic [csr_num_w-1:0] csr_ticlr  = 14'h044;

    localparam int ecode_w = 6;
    localparam int esubcode_w = 9;

    localparam logic [ecode_w-1:0] ecode_int = 6'h00;
    localparam logic [ecode_w-1:0] ecode_pil = 6'h01;
    localparam logic [ecode_w-1:0] ecode_pis = 6'h02;
    localparam logic [ecode_w-1:0] ecode_pif = 6'h03;
    localparam logic [ecode_w-1:0] ecode_pme = 6'h04;
    localparam logic [ecode_w-1:0] ecode_ppi = 6'h07;
    localparam logic [ecode_w-1:0] ecode_ade = 6'h08;
    localparam logic [ecode_w-1:0] ecode_ale = 6'h09;
    localparam logic [ecode_w-1:0] ecode_sys = 6'h0b;
    localparam logic [esubcode_w-1:0] esubcode_adem = 9'h001; // ade on data access

    localparam int int_w = 13;         // bit 10 unused
    localparam int timer_int_bit = 11;
    localparam logic [8:0] crmd_reset = 9'h008; // da set

    typedef struct packed {
        logic [xlen-1:0] rd_data;
        logic            redirect;
        logic [xlen-1:0] redirect_pc;
        logic            excp_taken;
        logic            ertn_taken;
    } csr_result_t;

endpackage

`default_nettype wire
